// ==== design/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Bundle width from rename
`define ID_WIDTH       2

// Reservation-station depths
`define INT_RS_DEPTH   8
`define INTM_RS_DEPTH  4
`define BR_RS_DEPTH    4
`define MEM_RS_DEPTH   4

// Micro-op field widths
`define ROB_IDX_W      6
`define PREG_W         6

`define PERF_W         32   // Block counter width

`endif

// ==== design/rs_types_pkg.sv ====
package rs_types_pkg;

    // Target reservation station of a micro-op
    typedef enum logic [1:0] {
        RS_INT  = 2'd0,   // Simple integer ALU ops
        RS_INTM = 2'd1,   // Multiply and divide
        RS_BR   = 2'd2,   // Branches and jumps
        RS_MEM  = 2'd3    // Loads and stores
    } rs_type_t;

endpackage

// ==== design/uop_types_pkg.sv ====
`include "core_settings.svh"

package uop_types_pkg;
    import rs_types_pkg::*;

    // Renamed micro-op as it leaves rename, 28 bits
    typedef struct packed {
        logic [`ROB_IDX_W-1:0]  rob_idx;     // Reorder-buffer tag
        rs_type_t               rs_type;     // Station the op goes to
        logic [7:0]             opcode;
        logic [`PREG_W-1:0]     dest_preg;
        logic [`PREG_W-1:0]     src_preg;
    } uop_t;

endpackage

// ==== design/dispatch_ctrl.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module dispatch_ctrl
import rs_types_pkg::*;
import uop_types_pkg::*;
(
    input  logic        clk,
    input  logic        in_valid,
    input  logic        uop_valid    [`ID_WIDTH],
    input  uop_t        uops         [`ID_WIDTH],
    output logic        in_ready,
    input  logic        int_rs_ready,
    input  logic        intm_rs_ready,
    input  logic        br_rs_ready,
    input  logic        mem_rs_ready,
    output logic        int_wr_en    [`ID_WIDTH],
    output uop_t        int_wr_uop   [`ID_WIDTH],
    output logic        intm_wr_en   [`ID_WIDTH],
    output uop_t        intm_wr_uop  [`ID_WIDTH],
    output logic        br_wr_en,
    output uop_t        br_wr_uop,
    output logic        mem_wr_en,
    output uop_t        mem_wr_uop,
    output logic        block_valid,
    output rs_type_t    block_type
);

    localparam int HIT_W = $clog2(`ID_WIDTH + 1);
    localparam logic [HIT_W-1:0] ONE_HIT = 'd1;

    logic               slot_ready  [`ID_WIDTH];   // Readiness of each slot's station
    logic               slot_go     [`ID_WIDTH];   // Slot is written this cycle
    logic [HIT_W-1:0]   br_hits;
    logic [HIT_W-1:0]   mem_hits;

    ////////////////////
    // Ready merge
    ////////////////////

    always_comb begin
        for (int i = 0; i < `ID_WIDTH; i++) begin
            case (uops[i].rs_type)
                RS_INT:  slot_ready[i] = int_rs_ready;
                RS_INTM: slot_ready[i] = intm_rs_ready;
                RS_BR:   slot_ready[i] = br_rs_ready;
                default: slot_ready[i] = mem_rs_ready;
            endcase
        end
    end

    // Whole bundle or nothing, empty slots never block
    always_comb begin
        in_ready = 1'b1;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (uop_valid[i] && !slot_ready[i]) in_ready = 1'b0;
        end
    end

    // Walk down so the lowest blocking slot wins
    always_comb begin
        block_type = RS_INT;
        for (int i = `ID_WIDTH - 1; i >= 0; i--) begin
            if (uop_valid[i] && !slot_ready[i]) block_type = uops[i].rs_type;
        end
    end

    assign block_valid = in_valid && !in_ready;

    ////////////////////
    // Steering
    ////////////////////

    generate
        for (genvar i = 0; i < `ID_WIDTH; i++) begin : g_go
            assign slot_go[i] = in_valid && in_ready && uop_valid[i];
        end
    endgenerate

    always_comb begin
        br_wr_en   = 1'b0;
        br_wr_uop  = '0;
        mem_wr_en  = 1'b0;
        mem_wr_uop = '0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            int_wr_en[i]   = slot_go[i] && (uops[i].rs_type == RS_INT);   // One lane per slot
            int_wr_uop[i]  = uops[i];
            intm_wr_en[i]  = slot_go[i] && (uops[i].rs_type == RS_INTM);
            intm_wr_uop[i] = uops[i];
            if (slot_go[i] && uops[i].rs_type == RS_BR) begin
                br_wr_en  = 1'b1;
                br_wr_uop = uops[i];
            end
            if (slot_go[i] && uops[i].rs_type == RS_MEM) begin
                mem_wr_en  = 1'b1;
                mem_wr_uop = uops[i];
            end
        end
    end

    // Count single-write targets per bundle
    always_comb begin
        br_hits  = '0;
        mem_hits = '0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (uop_valid[i] && uops[i].rs_type == RS_BR)  br_hits  = br_hits + ONE_HIT;
            if (uop_valid[i] && uops[i].rs_type == RS_MEM) mem_hits = mem_hits + ONE_HIT;
        end
    end

    // Rename must not pack two BR or two MEM ops, those queues take one write
    a_single_br_mem: assert property (@(posedge clk)
        (in_valid && in_ready) |-> (br_hits <= ONE_HIT && mem_hits <= ONE_HIT))
        else $error("bundle targets BR or MEM more than once");

endmodule

// ==== design/rs_queue.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module rs_queue
import uop_types_pkg::*;
#(
    parameter int DEPTH = `INT_RS_DEPTH   // Power of two
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_en        [`ID_WIDTH],
    input  uop_t    wr_uop       [`ID_WIDTH],
    output logic    rs_ready,
    output logic    issue_valid,
    output uop_t    issue_uop,
    input  logic    issue_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_t               entries   [DEPTH];
    logic [PTR_W-1:0]   head;                    // Oldest entry
    logic [PTR_W-1:0]   tail;                    // Next free slot
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   push_cnt;                // Enabled lanes this cycle
    logic [PTR_W-1:0]   lane_ptr  [`ID_WIDTH];   // Target entry of each lane
    logic               pop;

    ////////////////////
    // Lane compaction
    ////////////////////

    // Each enabled lane lands after the enabled lanes below it
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            lane_ptr[i] = tail + push_cnt[PTR_W-1:0];
            if (wr_en[i]) push_cnt = push_cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (wr_en[i]) entries[lane_ptr[i]] <= wr_uop[i];
        end
    end

    ////////////////////
    // Pointers
    ////////////////////

    assign pop = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (pop) head <= head + PTR_W'(1);
            tail  <= tail + push_cnt[PTR_W-1:0];
            count <= count + push_cnt - CNT_W'(pop);
        end
    end

    assign rs_ready    = (count <= CNT_W'(DEPTH - `ID_WIDTH));   // Room for a full bundle
    assign issue_valid = (count != '0);
    assign issue_uop   = entries[head];

    // Dispatch only writes when a full bundle fits
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (int'(count) + int'(push_cnt) <= DEPTH))
        else $error("rs_queue overflow");

endmodule

// ==== design/rs_mono_queue.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module rs_mono_queue
import uop_types_pkg::*;
#(
    parameter int DEPTH = `BR_RS_DEPTH   // Power of two
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_en,
    input  uop_t    wr_uop,
    output logic    rs_ready,
    output logic    issue_valid,
    output uop_t    issue_uop,
    input  logic    issue_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_t               entries [DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic               pop;

    assign pop = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (wr_en) entries[tail] <= wr_uop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en) tail <= tail + PTR_W'(1);
            if (pop)   head <= head + PTR_W'(1);
            count <= count + CNT_W'(wr_en) - CNT_W'(pop);
        end
    end

    assign rs_ready    = (count != CNT_W'(DEPTH));   // A pop this cycle does not count
    assign issue_valid = (count != '0);
    assign issue_uop   = entries[head];

    // Writes only arrive while a slot is free
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (count < CNT_W'(DEPTH)))
        else $error("rs_mono_queue overflow");

endmodule

// ==== design/dispatch_perf.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module dispatch_perf
import rs_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                block_valid,
    input  rs_type_t            block_type,
    output logic [`PERF_W-1:0]  perf_int_block,
    output logic [`PERF_W-1:0]  perf_intm_block,
    output logic [`PERF_W-1:0]  perf_br_block,
    output logic [`PERF_W-1:0]  perf_mem_block
);

    localparam logic [`PERF_W-1:0] PERF_INC = 'd1;

    ////////////////////
    // Block counters
    ////////////////////

    // One count per stalled cycle, charged to the first blocking station
    always_ff @(posedge clk) begin
        if (rst) begin
            perf_int_block  <= '0;
            perf_intm_block <= '0;
            perf_br_block   <= '0;
            perf_mem_block  <= '0;
        end else if (block_valid) begin
            case (block_type)
                RS_INT:  perf_int_block  <= perf_int_block + PERF_INC;
                RS_INTM: perf_intm_block <= perf_intm_block + PERF_INC;
                RS_BR:   perf_br_block   <= perf_br_block + PERF_INC;
                default: perf_mem_block  <= perf_mem_block + PERF_INC;
            endcase
        end
    end

endmodule

// ==== design/dispatch_top.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module dispatch_top
import rs_types_pkg::*;
import uop_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Rename side
    input  logic                in_valid,
    output logic                in_ready,
    input  logic                uop_valid [`ID_WIDTH],
    input  uop_t                uops      [`ID_WIDTH],
    // Issue ports
    output logic                int_issue_valid,
    output uop_t                int_issue_uop,
    input  logic                int_issue_ready,
    output logic                intm_issue_valid,
    output uop_t                intm_issue_uop,
    input  logic                intm_issue_ready,
    output logic                br_issue_valid,
    output uop_t                br_issue_uop,
    input  logic                br_issue_ready,
    output logic                mem_issue_valid,
    output uop_t                mem_issue_uop,
    input  logic                mem_issue_ready,
    // Performance counters
    output logic [`PERF_W-1:0]  perf_int_block,
    output logic [`PERF_W-1:0]  perf_intm_block,
    output logic [`PERF_W-1:0]  perf_br_block,
    output logic [`PERF_W-1:0]  perf_mem_block
);

    logic       int_rs_ready, intm_rs_ready, br_rs_ready, mem_rs_ready;
    logic       int_wr_en    [`ID_WIDTH];
    uop_t       int_wr_uop   [`ID_WIDTH];
    logic       intm_wr_en   [`ID_WIDTH];
    uop_t       intm_wr_uop  [`ID_WIDTH];
    logic       br_wr_en,  mem_wr_en;
    uop_t       br_wr_uop, mem_wr_uop;
    logic       block_valid;
    rs_type_t   block_type;

    dispatch_ctrl u_ctrl (.clk, .in_valid, .uop_valid, .uops, .in_ready,
        .int_rs_ready, .intm_rs_ready, .br_rs_ready, .mem_rs_ready,
        .int_wr_en, .int_wr_uop, .intm_wr_en, .intm_wr_uop,
        .br_wr_en, .br_wr_uop, .mem_wr_en, .mem_wr_uop,
        .block_valid, .block_type);

    ////////////////////
    // Stations
    ////////////////////

    rs_queue #(.DEPTH(`INT_RS_DEPTH)) int_rs (.clk, .rst,
        .wr_en(int_wr_en), .wr_uop(int_wr_uop), .rs_ready(int_rs_ready),
        .issue_valid(int_issue_valid), .issue_uop(int_issue_uop),
        .issue_ready(int_issue_ready));

    rs_queue #(.DEPTH(`INTM_RS_DEPTH)) intm_rs (.clk, .rst,
        .wr_en(intm_wr_en), .wr_uop(intm_wr_uop), .rs_ready(intm_rs_ready),
        .issue_valid(intm_issue_valid), .issue_uop(intm_issue_uop),
        .issue_ready(intm_issue_ready));

    rs_mono_queue #(.DEPTH(`BR_RS_DEPTH)) br_rs (.clk, .rst,
        .wr_en(br_wr_en), .wr_uop(br_wr_uop), .rs_ready(br_rs_ready),
        .issue_valid(br_issue_valid), .issue_uop(br_issue_uop),
        .issue_ready(br_issue_ready));

    rs_mono_queue #(.DEPTH(`MEM_RS_DEPTH)) mem_rs (.clk, .rst,
        .wr_en(mem_wr_en), .wr_uop(mem_wr_uop), .rs_ready(mem_rs_ready),
        .issue_valid(mem_issue_valid), .issue_uop(mem_issue_uop),
        .issue_ready(mem_issue_ready));

    dispatch_perf u_perf (.clk, .rst, .block_valid, .block_type,
        .perf_int_block, .perf_intm_block, .perf_br_block, .perf_mem_block);

endmodule

// ==== verification/tb_dispatch.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_dispatch
import rs_types_pkg::*;
import uop_types_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int CHECK_LEAD   = 4;    // Compare this long before each edge
    localparam int RESET_CYCLES = 5;
    localparam int STIM_CYCLES  = 400;
    localparam int MAX_CYCLES   = RESET_CYCLES + STIM_CYCLES + 195;   // Drain needs about 20
    localparam logic [`PERF_W-1:0] PERF_ONE = 'd1;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    logic                   uop_valid [`ID_WIDTH];
    uop_t                   uops      [`ID_WIDTH];
    logic                   int_issue_valid, intm_issue_valid, br_issue_valid, mem_issue_valid;
    uop_t                   int_issue_uop, intm_issue_uop, br_issue_uop, mem_issue_uop;
    logic                   int_issue_ready, intm_issue_ready, br_issue_ready, mem_issue_ready;
    logic [`PERF_W-1:0]     perf_int_block, perf_intm_block, perf_br_block, perf_mem_block;

    uop_t                   int_q[$], intm_q[$], br_q[$], mem_q[$];   // Station model
    logic [`PERF_W-1:0]     blocks [4];         // Expected block counts by station
    logic [`PERF_W-1:0]     accepted;
    logic [`PERF_W-1:0]     issued;
    logic [`ROB_IDX_W-1:0]  next_rob;
    logic                   stalled;            // Bundle must be held
    integer                 seed = 5400;
    int                     cycles = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dispatch_top dut (.*);

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_uop(input uop_t got, input uop_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: %s got %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_count(input logic [`PERF_W-1:0] got, input logic [`PERF_W-1:0] exp,
                               input string what);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp));
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Multi-write stations need room for a full bundle
    function automatic logic station_ready(input rs_type_t t);
        case (t)
            RS_INT:  return (`INT_RS_DEPTH - int_q.size()) >= `ID_WIDTH;
            RS_INTM: return (`INTM_RS_DEPTH - intm_q.size()) >= `ID_WIDTH;
            RS_BR:   return br_q.size() < `BR_RS_DEPTH;
            default: return mem_q.size() < `MEM_RS_DEPTH;
        endcase
    endfunction

    function automatic logic expected_accept();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (uop_valid[i] && !station_ready(uops[i].rs_type)) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic push_model(input uop_t u);
        case (u.rs_type)
            RS_INT:  int_q.push_back(u);
            RS_INTM: intm_q.push_back(u);
            RS_BR:   br_q.push_back(u);
            default: mem_q.push_back(u);
        endcase
    endtask

    always @(posedge clk) begin
        logic exp_ready;
        bit   charged;
        #(CLK_PERIOD - CHECK_LEAD);
        if (!rst) begin
            exp_ready = expected_accept();
            check_bit(in_ready, exp_ready, "in_ready");
            check_bit(int_issue_valid,  int_q.size() != 0,  "int_issue_valid");
            check_bit(intm_issue_valid, intm_q.size() != 0, "intm_issue_valid");
            check_bit(br_issue_valid,   br_q.size() != 0,   "br_issue_valid");
            check_bit(mem_issue_valid,  mem_q.size() != 0,  "mem_issue_valid");
            if (int_q.size() != 0)  check_uop(int_issue_uop, int_q[0], "int_issue_uop");
            if (intm_q.size() != 0) check_uop(intm_issue_uop, intm_q[0], "intm_issue_uop");
            if (br_q.size() != 0)   check_uop(br_issue_uop, br_q[0], "br_issue_uop");
            if (mem_q.size() != 0)  check_uop(mem_issue_uop, mem_q[0], "mem_issue_uop");
            check_count(perf_int_block,  blocks[RS_INT],  "perf_int_block");
            check_count(perf_intm_block, blocks[RS_INTM], "perf_intm_block");
            check_count(perf_br_block,   blocks[RS_BR],   "perf_br_block");
            check_count(perf_mem_block,  blocks[RS_MEM],  "perf_mem_block");

            stalled = in_valid && !exp_ready;
            charged = 1'b0;
            for (int i = 0; i < `ID_WIDTH; i++) begin
                if (in_valid && exp_ready && uop_valid[i]) begin   // Slot order
                    push_model(uops[i]);
                    accepted = accepted + PERF_ONE;
                end
                if (stalled && !charged && uop_valid[i] && !station_ready(uops[i].rs_type)) begin
                    blocks[uops[i].rs_type] = blocks[uops[i].rs_type] + PERF_ONE;
                    charged = 1'b1;
                end
            end

            if (int_issue_valid && int_issue_ready) void'(int_q.pop_front());
            if (intm_issue_valid && intm_issue_ready) void'(intm_q.pop_front());
            if (br_issue_valid && br_issue_ready) void'(br_q.pop_front());
            if (mem_issue_valid && mem_issue_ready) void'(mem_q.pop_front());
            issued = issued + PERF_ONE * (int_issue_valid & int_issue_ready)
                   + PERF_ONE * (intm_issue_valid & intm_issue_ready)
                   + PERF_ONE * (br_issue_valid & br_issue_ready)
                   + PERF_ONE * (mem_issue_valid & mem_issue_ready);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic new_bundle();
        logic [31:0] r;
        rs_type_t    t;
        bit          br_used;
        bit          mem_used;
        br_used  = 1'b0;
        mem_used = 1'b0;
        r = $random(seed);
        in_valid = (r[1:0] != 2'b00);
        for (int i = 0; i < `ID_WIDTH; i++) begin
            r = $random(seed);
            t = rs_type_t'(r[2:1]);
            if ((t == RS_BR && br_used) || (t == RS_MEM && mem_used))
                t = r[3] ? RS_INTM : RS_INT;   // BR and MEM take one op per bundle
            br_used  = br_used || (t == RS_BR);
            mem_used = mem_used || (t == RS_MEM);
            uop_valid[i] = r[0];
            uops[i] = '{rob_idx: next_rob, rs_type: t, opcode: r[15:8],
                        dest_preg: r[16 +: `PREG_W], src_preg: r[24 +: `PREG_W]};
            next_rob++;
        end
    endtask

    task automatic drive_issue_ready(input int cyc);
        logic [31:0] r;
        r = $random(seed);
        if (cyc >= 100 && cyc < 160) begin   // Long back-pressure so the stations fill up
            int_issue_ready  = 1'b0;
            intm_issue_ready = 1'b0;
            br_issue_ready   = 1'b0;
            mem_issue_ready  = 1'b0;
        end else begin
            int_issue_ready  = r[0];
            intm_issue_ready = r[1];
            br_issue_ready   = r[2];
            mem_issue_ready  = r[3];
        end
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        stalled  = 1'b0;
        accepted = '0;
        issued   = '0;
        next_rob = '0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            uop_valid[i] = 1'b0;
            uops[i]      = '0;
        end
        for (int s = 0; s < 4; s++) blocks[s] = '0;
        int_issue_ready  = 1'b0;
        intm_issue_ready = 1'b0;
        br_issue_ready   = 1'b0;
        mem_issue_ready  = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Idle state out of reset
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_bit(int_issue_valid, 1'b0, "int_issue_valid after reset");
        check_bit(intm_issue_valid, 1'b0, "intm_issue_valid after reset");
        check_bit(br_issue_valid, 1'b0, "br_issue_valid after reset");
        check_bit(mem_issue_valid, 1'b0, "mem_issue_valid after reset");
        check_count(perf_int_block, '0, "perf_int_block after reset");
        check_count(perf_intm_block, '0, "perf_intm_block after reset");
        check_count(perf_br_block, '0, "perf_br_block after reset");
        check_count(perf_mem_block, '0, "perf_mem_block after reset");

        for (int c = 0; c < STIM_CYCLES; c++) begin
            if (!stalled) new_bundle();
            drive_issue_ready(c);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        // Drain everything left in the stations
        in_valid = 1'b0;
        for (int i = 0; i < `ID_WIDTH; i++) uop_valid[i] = 1'b0;
        int_issue_ready  = 1'b1;
        intm_issue_ready = 1'b1;
        br_issue_ready   = 1'b1;
        mem_issue_ready  = 1'b1;
        while (int_issue_valid || intm_issue_valid || br_issue_valid || mem_issue_valid) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);
        #DRIVE_DELAY;

        check_count(issued, accepted, "issued micro-op count");
        check_bit(int_q.size() == 0 && intm_q.size() == 0 && br_q.size() == 0
                  && mem_q.size() == 0, 1'b1, "model empty after drain");
        check_count(perf_int_block, blocks[RS_INT], "final perf_int_block");
        check_count(perf_intm_block, blocks[RS_INTM], "final perf_intm_block");
        check_count(perf_br_block, blocks[RS_BR], "final perf_br_block");
        check_count(perf_mem_block, blocks[RS_MEM], "final perf_mem_block");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+design
design/rs_types_pkg.sv
design/uop_types_pkg.sv
design/dispatch_ctrl.sv
design/rs_queue.sv
design/rs_mono_queue.sv
design/dispatch_perf.sv
design/dispatch_top.sv
verification/tb_dispatch.sv

// ==== Makefile ====
# Verilator build and run for the dispatch testbench

TOP             ?= tb_dispatch
SRC_F           ?= src.f
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP SRC_F OBJ_DIR VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SRC_F)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
